// File: design/lc3_pkg.sv
/* shared widths, instruction field positions, reset pc,
   opcode, sequencer, memory port and datapath command enums */
package lc3_pkg;

    ////////////////////
    // widths and reset values
    ////////////////////
    localparam int word_w    = 16;
    localparam int reg_count = 8;
    localparam int reg_idx_w = $clog2(reg_count);
    localparam logic [word_w-1:0] reset_pc = '0;

    // instruction field positions
    localparam int op_lsb    = 12;
    localparam int dr_lsb    = 9;
    localparam int sr1_lsb   = 6;
    localparam int sr2_lsb   = 0;
    localparam int imm_bit   = 5;
    localparam int imm5_w    = 5;
    localparam int off9_w    = 9;
    // branch condition bits share the dr field
    localparam int cond_n_bit = 11;
    localparam int cond_z_bit = 10;
    localparam int cond_p_bit = 9;

    typedef logic [word_w-1:0]    word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    ////////////////////
    // opcodes
    ////////////////////
    // full map so unused codes can be named in decode
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ld   = 4'b0010,
        op_st   = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_res  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } opcode_t;

    ////////////////////
    // state machines
    ////////////////////
    typedef enum logic [2:0] {
        fetch,
        fetch_wait,
        decode,
        execute,
        mem_access,
        mem_wait
    } seq_state_t;

    // memory port request tracking
    typedef enum logic [1:0] {
        mp_idle,
        mp_request,
        mp_resp_wait
    } port_state_t;

    // one command per cycle from sequencer to datapath
    typedef enum logic [2:0] {
        dp_idle,
        dp_load_ir,
        dp_alu_write,
        dp_lea_write,
        dp_load_write,
        dp_branch,
        dp_jump
    } dp_cmd_t;

    typedef enum logic {
        addr_pc,
        addr_offset
    } addr_sel_t;

endpackage

// File: design/lc3_mem_port.sv
/* memory bus port, holds one request under back-pressure
   and waits for the read response strobe */
module lc3_mem_port
    import lc3_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    // access side, from sequencer and datapath
    input  logic  acc_start,
    input  logic  acc_write,
    input  word_t acc_addr,
    input  word_t acc_wdata,
    output logic  acc_done,
    output word_t acc_rdata,
    // external bus
    output logic  mem_valid,
    output logic  mem_write,
    input  logic  mem_ready,
    output word_t mem_addr,
    output word_t mem_wdata,
    input  logic  mem_rvalid,
    input  word_t mem_rdata
);

    port_state_t state;
    logic        write_q;
    logic        write_done;
    word_t       addr_q;
    word_t       wdata_q;
    logic        take_req;
    logic        transfer;

    // only accept a new access when nothing is in flight
    assign take_req = acc_start && (state == mp_idle);
    assign transfer = mem_valid && mem_ready;

    ////////////////////
    // request tracking
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= mp_idle;
            write_q    <= 1'b0;
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            if (take_req) begin
                write_q <= acc_write;
            end
            case (state)
                mp_idle: begin
                    if (acc_start) begin
                        state <= mp_request;
                    end
                end
                mp_request: begin
                    // held here while the memory stalls
                    if (transfer) begin
                        if (write_q) begin
                            state      <= mp_idle;
                            write_done <= 1'b1;
                        end else begin
                            state <= mp_resp_wait;
                        end
                    end
                end
                mp_resp_wait: begin
                    if (mem_rvalid) begin
                        state <= mp_idle;
                    end
                end
                default: state <= mp_idle;
            endcase
        end
    end

    // payload, captured with the request
    always_ff @(posedge clk) begin
        if (take_req) begin
            addr_q  <= acc_addr;
            wdata_q <= acc_wdata;
        end
    end

    assign mem_valid = (state == mp_request);
    assign mem_write = write_q;
    assign mem_addr  = addr_q;
    assign mem_wdata = wdata_q;

    // write done a cycle after transfer, read done with the response
    assign acc_done  = write_done || ((state == mp_resp_wait) && mem_rvalid);
    assign acc_rdata = mem_rdata;

endmodule

// File: design/lc3_datapath.sv
/* instruction register, pc, register file, alu and nzp flags,
   memory address and store data selection */
module lc3_datapath
    import lc3_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  dp_cmd_t   dp_cmd,
    input  addr_sel_t addr_sel,
    input  word_t     acc_rdata,
    output word_t     acc_addr,
    output word_t     acc_wdata,
    output opcode_t   opcode,
    output logic      branch_taken
);

    word_t    ir;
    word_t    pc;
    word_t    regs [reg_count];
    logic     flag_n;
    logic     flag_z;
    logic     flag_p;

    // decoded fields
    reg_idx_t dr;
    reg_idx_t sr1;
    reg_idx_t sr2;
    reg_idx_t base_r;
    logic     imm_flag;
    word_t    imm5_sx;
    word_t    off9_sx;

    word_t    src_a;
    word_t    src_b;
    word_t    alu_result;
    word_t    pc_offset;
    word_t    wb_value;
    logic     reg_we;

    ////////////////////
    // field extraction
    ////////////////////
    assign opcode   = opcode_t'(ir[word_w-1:op_lsb]);
    assign dr       = ir[dr_lsb +: reg_idx_w];
    assign sr1      = ir[sr1_lsb +: reg_idx_w];
    assign sr2      = ir[sr2_lsb +: reg_idx_w];
    // jmp base shares the sr1 slot
    assign base_r   = ir[sr1_lsb +: reg_idx_w];
    assign imm_flag = ir[imm_bit];
    assign imm5_sx  = {{(word_w-imm5_w){ir[imm5_w-1]}}, ir[imm5_w-1:0]};
    assign off9_sx  = {{(word_w-off9_w){ir[off9_w-1]}}, ir[off9_w-1:0]};

    // pc already points past the instruction here
    assign pc_offset = pc + off9_sx;

    ////////////////////
    // alu
    ////////////////////
    assign src_a = regs[sr1];
    assign src_b = imm_flag ? imm5_sx : regs[sr2];

    always_comb begin
        case (opcode)
            op_add:  alu_result = src_a + src_b;
            op_and:  alu_result = src_a & src_b;
            default: alu_result = ~src_a;
        endcase
    end

    // value for register write and flag update
    always_comb begin
        reg_we   = 1'b0;
        wb_value = alu_result;
        case (dp_cmd)
            dp_alu_write: begin
                reg_we = 1'b1;
            end
            dp_lea_write: begin
                reg_we   = 1'b1;
                wb_value = pc_offset;
            end
            dp_load_write: begin
                reg_we   = 1'b1;
                wb_value = acc_rdata;
            end
            default: reg_we = 1'b0;
        endcase
    end

    // nzp against the condition bits of the ir
    assign branch_taken = (ir[cond_n_bit] && flag_n) ||
                          (ir[cond_z_bit] && flag_z) ||
                          (ir[cond_p_bit] && flag_p);

    ////////////////////
    // state update
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            ir     <= '0;
            pc     <= reset_pc;
            flag_n <= 1'b0;
            flag_z <= 1'b0;
            flag_p <= 1'b0;
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (dp_cmd)
                dp_load_ir: begin
                    ir <= acc_rdata;
                    pc <= pc + word_t'(1);
                end
                dp_branch: pc <= pc_offset;
                dp_jump:   pc <= regs[base_r];
                default: ;
            endcase
            if (reg_we) begin
                regs[dr] <= wb_value;
                flag_n   <= wb_value[word_w-1];
                flag_z   <= (wb_value == '0);
                flag_p   <= !wb_value[word_w-1] && (wb_value != '0);
            end
        end
    end

    // memory address and store data
    assign acc_addr  = (addr_sel == addr_offset) ? pc_offset : pc;
    // st keeps its source in the dr slot
    assign acc_wdata = regs[dr];

endmodule

// File: design/lc3_sequencer.sv
/* fetch, decode and execute state machine driving
   datapath commands and memory accesses */
module lc3_sequencer
    import lc3_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  opcode_t   opcode,
    input  logic      branch_taken,
    input  logic      acc_done,
    output logic      acc_start,
    output logic      acc_write,
    output dp_cmd_t   dp_cmd,
    output addr_sel_t addr_sel
);

    seq_state_t state;
    seq_state_t state_next;
    dp_cmd_t    exec_cmd;
    logic       needs_mem;
    logic       is_store;

    ////////////////////
    // opcode mapping
    ////////////////////
    always_comb begin
        exec_cmd  = dp_idle;
        needs_mem = 1'b0;
        case (opcode)
            op_add, op_and, op_not: begin
                exec_cmd = dp_alu_write;
            end
            op_lea: begin
                exec_cmd = dp_lea_write;
            end
            op_br: begin
                // not taken just falls through to fetch
                exec_cmd = branch_taken ? dp_branch : dp_idle;
            end
            op_jmp: begin
                exec_cmd = dp_jump;
            end
            op_ld, op_st: begin
                needs_mem = 1'b1;
            end
            // rti, reserved and unsupported codes
            op_jsr, op_ldr, op_str, op_rti, op_ldi, op_sti, op_res, op_trap: begin
                exec_cmd = dp_idle;
            end
            default: exec_cmd = dp_idle;
        endcase
    end

    assign is_store = (opcode == op_st);

    ////////////////////
    // next state and outputs
    ////////////////////
    always_comb begin
        state_next = state;
        acc_start  = 1'b0;
        acc_write  = 1'b0;
        dp_cmd     = dp_idle;
        addr_sel   = addr_pc;
        case (state)
            fetch: begin
                acc_start  = 1'b1;
                state_next = fetch_wait;
            end
            fetch_wait: begin
                // latency varies, wait for the port
                if (acc_done) begin
                    dp_cmd     = dp_load_ir;
                    state_next = decode;
                end
            end
            decode: begin
                // ir settles, opcode valid from here on
                state_next = execute;
            end
            execute: begin
                dp_cmd     = exec_cmd;
                state_next = needs_mem ? mem_access : fetch;
            end
            mem_access: begin
                acc_start  = 1'b1;
                acc_write  = is_store;
                addr_sel   = addr_offset;
                state_next = mem_wait;
            end
            mem_wait: begin
                if (acc_done) begin
                    // ld writes with the response, st has nothing left
                    if (!is_store) begin
                        dp_cmd = dp_load_write;
                    end
                    state_next = fetch;
                end
            end
            default: state_next = fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: design/lc3_core.sv
/* processor top, memory port, sequencer and datapath */
module lc3_core
    import lc3_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output logic  mem_valid,
    output logic  mem_write,
    input  logic  mem_ready,
    output word_t mem_addr,
    output word_t mem_wdata,
    input  logic  mem_rvalid,
    input  word_t mem_rdata
);

    // access handshake
    logic      acc_start;
    logic      acc_write;
    logic      acc_done;
    word_t     acc_addr;
    word_t     acc_wdata;
    word_t     acc_rdata;

    // sequencer and datapath
    dp_cmd_t   dp_cmd;
    addr_sel_t addr_sel;
    opcode_t   opcode;
    logic      branch_taken;

    lc3_mem_port port0 (
        .clk        (clk),
        .reset      (reset),
        .acc_start  (acc_start),
        .acc_write  (acc_write),
        .acc_addr   (acc_addr),
        .acc_wdata  (acc_wdata),
        .acc_done   (acc_done),
        .acc_rdata  (acc_rdata),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    lc3_sequencer seq0 (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .acc_done     (acc_done),
        .acc_start    (acc_start),
        .acc_write    (acc_write),
        .dp_cmd       (dp_cmd),
        .addr_sel     (addr_sel)
    );

    lc3_datapath dp0 (
        .clk          (clk),
        .reset        (reset),
        .dp_cmd       (dp_cmd),
        .addr_sel     (addr_sel),
        .acc_rdata    (acc_rdata),
        .acc_addr     (acc_addr),
        .acc_wdata    (acc_wdata),
        .opcode       (opcode),
        .branch_taken (branch_taken)
    );

endmodule

// File: bench/lc3_tb_assert.sv
/* bound checker for lc3_core, expected store table
   and bus handshake assertions */
module lc3_tb_assert
    import lc3_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  mem_valid,
    input logic  mem_write,
    input logic  mem_ready,
    input word_t mem_addr,
    input word_t mem_wdata,
    input logic  mem_rvalid
);

    localparam logic [3:0] store_total = 4'd9;
    // value held by every store that a branch or jump must skip
    localparam word_t marker = 16'hdead;

    ////////////////////
    // expected stores, program order
    ////////////////////
    // add reg, add -3, add 7, and reg, and 12, not, not again after brz,
    // add 5 after brn, lea address through jmp
    localparam word_t exp_addr [store_total] = '{
        16'h0040, 16'h0041, 16'h0042, 16'h0043, 16'h0044,
        16'h0045, 16'h0046, 16'h0047, 16'h0048
    };
    localparam word_t exp_data [store_total] = '{
        16'h2143, 16'h1231, 16'h0f16, 16'h0204, 16'h0004,
        16'hf0f0, 16'hf0f0, 16'h0005, 16'h0028
    };

    logic [3:0] store_count;
    logic [3:0] table_idx;
    logic       write_xfer;
    logic       read_xfer;
    logic       read_pending;
    logic       all_stores_seen;
    logic       any_fail;

    // one flag per property, raised by its action block
    logic       bad_extra  = 1'b0;
    logic       bad_addr   = 1'b0;
    logic       bad_data   = 1'b0;
    logic       bad_marker = 1'b0;
    logic       bad_hold   = 1'b0;
    logic       bad_reset  = 1'b0;
    logic       bad_read   = 1'b0;

    assign write_xfer = mem_valid && mem_ready && mem_write;
    assign read_xfer  = mem_valid && mem_ready && !mem_write;
    // clamp so an extra store still indexes the table
    assign table_idx  = (store_count < store_total) ? store_count : 4'd0;

    assign all_stores_seen = (store_count == store_total);
    assign any_fail = bad_extra || bad_addr || bad_data || bad_marker ||
                      bad_hold || bad_reset || bad_read;

    always_ff @(posedge clk) begin
        if (reset) begin
            store_count  <= '0;
            read_pending <= 1'b0;
        end else begin
            if (write_xfer && (store_count != 4'hf)) begin
                store_count <= store_count + 4'd1;
            end
            // response strobe closes the outstanding read
            if (read_xfer) begin
                read_pending <= 1'b1;
            end else if (mem_rvalid) begin
                read_pending <= 1'b0;
            end
        end
    end

    ////////////////////
    // store results
    ////////////////////
    store_extra_chk: assert property (@(posedge clk) disable iff (reset)
        write_xfer |-> (store_count < store_total))
    else begin
        $error("a store to %h came after the last expected store", $sampled(mem_addr));
        bad_extra = 1'b1;
    end

    store_addr_chk: assert property (@(posedge clk) disable iff (reset)
        write_xfer && (store_count < store_total) |-> (mem_addr == exp_addr[table_idx]))
    else begin
        $error("error mem_addr %h expected %h", $sampled(mem_addr),
               exp_addr[$sampled(table_idx)]);
        bad_addr = 1'b1;
    end

    store_data_chk: assert property (@(posedge clk) disable iff (reset)
        write_xfer && (store_count < store_total) |-> (mem_wdata == exp_data[table_idx]))
    else begin
        $error("error mem_wdata %h expected %h", $sampled(mem_wdata),
               exp_data[$sampled(table_idx)]);
        bad_data = 1'b1;
    end

    // skipped stores must never reach the bus
    marker_chk: assert property (@(posedge clk) disable iff (reset)
        write_xfer |-> (mem_wdata != marker))
    else begin
        $error("error mem_wdata %h at mem_addr %h is the skipped marker",
               $sampled(mem_wdata), $sampled(mem_addr));
        bad_marker = 1'b1;
    end

    ////////////////////
    // handshake
    ////////////////////
    hold_chk: assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write) &&
                                    $stable(mem_addr) && $stable(mem_wdata))
    else begin
        $error("request changed or dropped while mem_ready was low");
        bad_hold = 1'b1;
    end

    // covers the reset cycles and the first cycle after
    reset_idle_chk: assert property (@(posedge clk)
        reset |=> !mem_valid)
    else begin
        $error("mem_valid was high during or right after reset");
        bad_reset = 1'b1;
    end

    one_read_chk: assert property (@(posedge clk) disable iff (reset)
        read_pending |-> !$rose(mem_valid))
    else begin
        $error("a new request started before the read response arrived");
        bad_read = 1'b1;
    end

endmodule

bind lc3_core lc3_tb_assert chk0 (
    .clk        (clk),
    .reset      (reset),
    .mem_valid  (mem_valid),
    .mem_write  (mem_write),
    .mem_ready  (mem_ready),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rvalid (mem_rvalid)
);

// File: bench/lc3_tb.sv
/* testbench for lc3_core, clock and reset, memory model with program
   image, lfsr driven stalls and read latency, watchdog and end of run */
module lc3_tb
    import lc3_pkg::*;
();

    localparam int clk_half     = 5;
    localparam int reset_cycles = 5;
    // instructions run until the halt loop has been fetched twice
    localparam int prog_instr   = 32;
    // worst case two accesses of about 12 cycles plus decode and execute
    localparam int instr_cycles = 2 * 12 + 3;
    localparam int watch_cycles = 2 * prog_instr * instr_cycles + reset_cycles;
    localparam logic [7:0] halt_addr = 8'h29;

    logic        clk;
    logic        reset;
    logic        mem_valid;
    logic        mem_write;
    logic        mem_ready;
    word_t       mem_addr;
    word_t       mem_wdata;
    logic        mem_rvalid;
    word_t       mem_rdata;

    word_t       mem [256];
    logic [31:0] lfsr;
    logic [3:0]  halt_fetches;

    lc3_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    always #clk_half clk = ~clk;

    ////////////////////
    // random source
    ////////////////////
    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    ////////////////////
    // program image
    ////////////////////
    function automatic word_t image_word(input logic [7:0] a);
        case (a)
            // operands r1 r2, then add forms
            8'h00: return 16'h222f;
            8'h01: return 16'h242f;
            8'h02: return 16'h1642;
            8'h03: return 16'h363c;
            8'h04: return 16'h187d;
            8'h05: return 16'h383b;
            8'h06: return 16'h1aa7;
            8'h07: return 16'h3a3a;
            // and, not
            8'h08: return 16'h5642;
            8'h09: return 16'h3639;
            8'h0a: return 16'h586c;
            8'h0b: return 16'h3838;
            8'h0c: return 16'h9abf;
            8'h0d: return 16'h3a37;
            // brz with n set falls through to the store
            8'h0e: return 16'h0401;
            8'h0f: return 16'h3a36;
            // r7 gets the marker, brz taken skips its store
            8'h10: return 16'h2e21;
            8'h11: return 16'h5da0;
            8'h12: return 16'h0401;
            8'h13: return 16'h3e33;
            8'h14: return 16'h1da5;
            8'h15: return 16'h0801;
            8'h16: return 16'h3c30;
            // lea then jmp over another marker store
            8'h17: return 16'he010;
            8'h18: return 16'hc000;
            8'h19: return 16'h3e2e;
            // jump target and halt loop
            8'h28: return 16'h301f;
            8'h29: return 16'h0fff;
            // data words
            8'h30: return 16'h1234;
            8'h31: return 16'h0f0f;
            8'h32: return 16'hdead;
            // reserved opcode, a no-op if ever run
            default: return {8'hd0, a};
        endcase
    endfunction

    ////////////////////
    // memory model
    ////////////////////
    initial begin : memory_model
        logic       b0;
        logic       b1;
        logic [2:0] lat;
        logic [2:0] wait_left;
        word_t      read_word;
        lfsr         = 32'h35c299e1;
        wait_left    = '0;
        read_word    = '0;
        mem_ready    <= 1'b0;
        mem_rvalid   <= 1'b0;
        mem_rdata    <= '0;
        halt_fetches <= '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] <= image_word(8'(i));
        end
        forever begin
            @(posedge clk);
            mem_rvalid <= 1'b0;
            if (mem_valid && mem_ready && mem_write) begin
                mem[mem_addr[7:0]] <= mem_wdata;
            end else if (mem_valid && mem_ready) begin
                // read latency 1 to 4 cycles
                b0  = random_bit();
                b1  = random_bit();
                lat = {1'b0, b1, b0} + 3'd1;
                if ((mem_addr[7:0] == halt_addr) && (halt_fetches != 4'hf)) begin
                    halt_fetches <= halt_fetches + 4'd1;
                end
                if (lat == 3'd1) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= mem[mem_addr[7:0]];
                end else begin
                    read_word = mem[mem_addr[7:0]];
                    wait_left = lat - 3'd1;
                end
            end else if (wait_left != 3'd0) begin
                wait_left = wait_left - 3'd1;
                if (wait_left == 3'd0) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= read_word;
                end
            end
            // ready about three cycles in four
            b0 = random_bit();
            b1 = random_bit();
            mem_ready <= b0 | b1;
        end
    end

    ////////////////////
    // run control
    ////////////////////
    initial begin : run_control
        clk = 1'b0;
        reset <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        // halt loop fetches its own address over and over
        while (halt_fetches < 4'd2) begin
            @(negedge clk);
        end
        if (!dut0.chk0.all_stores_seen || dut0.chk0.any_fail) begin
            $display("halt loop reached with %0d stores seen or with failed checks",
                     dut0.chk0.store_count);
            $display("Something failed");
            $fatal(1, "run ended without the full store table");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

    initial begin : fail_monitor
        @(negedge clk);
        while (!dut0.chk0.any_fail) begin
            @(negedge clk);
        end
        $display("Something failed");
        $fatal(1, "assertion check failed");
    end

    initial begin : watchdog
        repeat (watch_cycles) @(posedge clk);
        $display("timeout, halt loop not reached within %0d cycles", watch_cycles);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: lc3_core.f
design/lc3_pkg.sv
design/lc3_mem_port.sv
design/lc3_datapath.sv
design/lc3_sequencer.sv
design/lc3_core.sv
bench/lc3_tb_assert.sv
bench/lc3_tb.sv

// File: Makefile
# Verilator build and run of the lc3_core testbench

VERILATOR ?= verilator
TOP       ?= lc3_tb
FILELIST  ?= lc3_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
# keep running after an assertion so the testbench can report
SIM_ARGS  ?= +verilator+error+limit+100

FAIL_MSG  := Something failed
PASS_MSG  := Everything OK
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
